// File: idu_pkg.sv
// RV64 decode types only; decode_t field order is the bit layout that execute receives
`default_nettype none

package idu_pkg;

  localparam int XLEN      = 64;
  localparam int NR_REGS   = 32;
  localparam logic [31:0] INST_MRET = 32'h3020_0073;

  typedef enum logic [6:0] {
    opc_load      = 7'b0000011,
    opc_op_imm    = 7'b0010011,
    opc_auipc     = 7'b0010111,
    opc_op_imm_32 = 7'b0011011,
    opc_store     = 7'b0100011,
    opc_op        = 7'b0110011,
    opc_lui       = 7'b0110111,
    opc_op_32     = 7'b0111011,
    opc_branch    = 7'b1100011,
    opc_jalr      = 7'b1100111,
    opc_jal       = 7'b1101111,
    opc_system    = 7'b1110011
  } opcode_e;

  typedef enum logic [4:0] {
    alu_add  = 5'b00000, alu_sub    = 5'b00001, alu_slt    = 5'b00010, alu_sltu  = 5'b00011,
    alu_xor  = 5'b00100, alu_and    = 5'b00101, alu_or     = 5'b00110, alu_sll   = 5'b00111,
    alu_srl  = 5'b01000, alu_sra    = 5'b01001, alu_mul    = 5'b01010, alu_div   = 5'b01011,
    alu_divu = 5'b01100, alu_rem    = 5'b01101, alu_remu   = 5'b01110, alu_copy_imm = 5'b01111,
    alu_mulh = 5'b11001, alu_mulhsu = 5'b11010, alu_mulhu  = 5'b11011, alu_none  = 5'b11111
  } alu_op_e;

  // unsigned branches reuse lt/ge and alu_sltu marks them
  typedef enum logic [2:0] {
    br_none = 3'b000, br_jal = 3'b001, br_jalr = 3'b010,
    br_eq   = 3'b100, br_ne  = 3'b101, br_lt   = 3'b110, br_ge = 3'b111
  } branch_e;

  typedef enum logic [2:0] {
    mem_byte = 3'b000, mem_byte_u = 3'b001, mem_half  = 3'b010, mem_half_u = 3'b011,
    mem_word = 3'b100, mem_word_u = 3'b101, mem_dword = 3'b110, mem_none   = 3'b111
  } mem_op_e;

  typedef enum logic [3:0] {
    ex_csrrw = 4'b0000, ex_csrrs  = 4'b0001, ex_mret = 4'b1100,
    ex_ecall = 4'b1101, ex_ebreak = 4'b1110, ex_none = 4'b1111
  } ex_op_e;

  typedef enum logic [2:0] {
    imm_i = 3'd0, imm_u = 3'd1, imm_s = 3'd2, imm_b = 3'd3, imm_j = 3'd4, imm_none = 3'd5
  } imm_fmt_e;

  typedef enum logic [1:0] {
    b_rs2 = 2'd0, b_imm = 2'd1, b_four = 2'd2
  } b_src_e;

  typedef struct packed {
    alu_op_e         alu_op;
    logic            a_is_pc;
    b_src_e          b_src;
    logic            word_cut;
    logic            reg_wr;
    logic            mem_to_reg;
    logic            mem_wr;
    logic            mem_rd;
    mem_op_e         mem_op;
    branch_e         branch;
    ex_op_e          ex_op;
    logic            csr_sel;
    logic            csr_wr;
    logic            csr_rd;
    logic            raise_intr;
    logic            intr_ret;
    logic            invalid;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
    logic [XLEN-1:0] imm;
    logic [4:0]      zimm;   // zero-extended downstream
  } decode_t;

  typedef struct packed {
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
  } operand_t;

endpackage

`default_nettype wire

// File: mux_key.sv
// table keys must be distinct; with no match the output falls back to i_default
`timescale 1ns/10ps
`default_nettype none

module mux_key #(
  parameter int NR_KEY   = 2,
  parameter int KEY_LEN  = 1,
  parameter int DATA_LEN = 1
) (
  input  wire [KEY_LEN-1:0]                       i_key,
  input  wire [DATA_LEN-1:0]                      i_default,
  input  wire [NR_KEY-1:0][KEY_LEN+DATA_LEN-1:0]  i_lut,
  output logic [DATA_LEN-1:0]                     o_out
);

  logic [NR_KEY-1:0]   hit;
  logic [DATA_LEN-1:0] sel;

  always_comb begin
    sel = '0;
    for (int n = 0; n < NR_KEY; n++) begin
      hit[n] = i_lut[n][KEY_LEN+DATA_LEN-1 -: KEY_LEN] == i_key;
      sel    = sel | ({DATA_LEN{hit[n]}} & i_lut[n][DATA_LEN-1:0]);  // and-or select
    end
  end

  assign o_out = |hit ? sel : i_default;

  a_one_key: assert final ($isunknown(hit) || $onehot0(hit))
    else $error("mux_key: %0d table keys match", $countones(hit));

endmodule

`default_nettype wire

// File: imm_gen.sv
// immediates sign-extend from inst[31]; B and J are already scaled by two, none gives zero
`timescale 1ns/10ps
`default_nettype none

module imm_gen
  import idu_pkg::*;
(
  input  wire [31:0]      i_inst,
  input  wire imm_fmt_e   i_fmt,
  output logic [XLEN-1:0] o_imm
);

  logic [XLEN-1:0] val_i;
  logic [XLEN-1:0] val_u;
  logic [XLEN-1:0] val_s;
  logic [XLEN-1:0] val_b;
  logic [XLEN-1:0] val_j;

  assign val_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign val_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign val_s = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign val_b = {{52{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign val_j = {{44{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  mux_key #(.NR_KEY(5), .KEY_LEN(3), .DATA_LEN(XLEN)) u_fmt_mux (
    .i_key     (i_fmt),
    .i_default ({XLEN{1'b0}}),
    .i_lut     ({imm_i, val_i,
                 imm_u, val_u,
                 imm_s, val_s,
                 imm_b, val_b,
                 imm_j, val_j}),
    .o_out     (o_imm)
  );

endmodule

`default_nettype wire

// File: idu.sv
// RV64IM plus csrrw/csrrs, ecall, ebreak, mret; every other nonzero word decodes as invalid
`timescale 1ns/10ps
`default_nettype none

module idu
  import idu_pkg::*;
(
  input  wire [31:0] i_inst,
  output decode_t    o_dec
);

  logic [6:0] opcode;
  logic [2:0] f3;
  logic [6:0] f7;
  logic [7:0] f3d;

  assign opcode = i_inst[6:0];
  assign f3     = i_inst[14:12];
  assign f7     = i_inst[31:25];
  assign f3d    = 8'b1 << f3;  // one-hot funct3

  wire is_op      = opcode == opc_op;
  wire is_op32    = opcode == opc_op_32;
  wire is_opimm   = opcode == opc_op_imm;
  wire is_opimm32 = opcode == opc_op_imm_32;
  wire is_branch  = opcode == opc_branch;
  wire is_system  = opcode == opc_system;
  wire is_rr      = is_op | is_op32;
  wire f7_zero    = f7 == 7'b0000000;
  wire f7_alt     = f7 == 7'b0100000;
  // rv64 shamt is 6 bits, so only f7[6:1] qualifies op-imm shifts
  wire sh_ok      = (is_opimm & (f7[6:1] == 6'b000000)) | ((is_opimm32 | is_rr) & f7_zero);
  wire sha_ok     = (is_opimm & (f7[6:1] == 6'b010000)) | ((is_opimm32 | is_rr) & f7_alt);
  wire ar64       = is_opimm | (is_op & f7_zero);
  wire ar32       = is_opimm32 | (is_op32 & f7_zero);
  wire mx         = is_rr & (f7 == 7'b0000001);  // M extension

  wire inst_lui    = opcode == opc_lui;
  wire inst_auipc  = opcode == opc_auipc;
  wire inst_jal    = opcode == opc_jal;
  wire inst_jalr   = (opcode == opc_jalr) & f3d[0];
  wire inst_load   = (opcode == opc_load) & ~f3d[7];
  wire inst_store  = (opcode == opc_store) & ~f3[2];
  wire inst_beq    = is_branch & f3d[0];
  wire inst_bne    = is_branch & f3d[1];
  wire inst_blt    = is_branch & f3d[4];
  wire inst_bge    = is_branch & f3d[5];
  wire inst_bltu   = is_branch & f3d[6];
  wire inst_bgeu   = is_branch & f3d[7];
  wire inst_branch = |{inst_beq, inst_bne, inst_blt, inst_bge, inst_bltu, inst_bgeu};
  wire inst_csrrw  = is_system & f3d[1];
  wire inst_csrrs  = is_system & f3d[2];
  wire inst_ecall  = is_system & f3d[0] & (i_inst[31:20] == 12'h000);
  wire inst_ebreak = is_system & f3d[0] & (i_inst[31:20] == 12'h001);
  wire inst_mret   = i_inst == INST_MRET;

  logic [18:0] alu_key;
  assign alu_key = {
    inst_lui,
    |{inst_auipc, inst_jal, inst_jalr, inst_load, inst_store, (ar64 | ar32) & f3d[0]},
    is_rr & f7_alt & f3d[0],
    |{inst_beq, inst_bne, inst_blt, inst_bge, ar64 & f3d[2]},  // signed compare
    |{inst_bltu, inst_bgeu, ar64 & f3d[3]},
    ar64 & f3d[4],
    ar64 & f3d[7],
    ar64 & f3d[6],
    sh_ok & f3d[1],
    sh_ok & f3d[5],
    sha_ok & f3d[5],
    mx & f3d[0],
    mx & is_op & f3d[1],
    mx & is_op & f3d[2],
    mx & is_op & f3d[3],
    mx & f3d[4],
    mx & f3d[5],
    mx & f3d[6],
    mx & f3d[7]
  };

  wire       arith   = |alu_key;
  wire       type_r  = is_rr & arith;
  wire       type_i  = |{(is_opimm | is_opimm32) & arith, inst_jalr, inst_load,
                         inst_csrrw, inst_csrrs, inst_ebreak};
  wire       type_u  = inst_lui | inst_auipc;
  wire [5:0] fmt_vec = {type_r, type_i, type_u, inst_store, inst_branch, inst_jal};

  a_one_fmt: assert final ($isunknown(fmt_vec) || $onehot0(fmt_vec))
    else $error("idu: several formats for %h", i_inst);

  imm_fmt_e        fmt;
  ex_op_e          ex_op;
  logic [XLEN-1:0] imm;
  logic [4:0]      alu_code;
  logic [2:0]      mem_code;
  logic [2:0]      br_code;

  always_comb begin
    if (type_i) fmt = imm_i;
    else if (type_u) fmt = imm_u;
    else if (inst_store) fmt = imm_s;
    else if (inst_branch) fmt = imm_b;
    else if (inst_jal) fmt = imm_j;
    else fmt = imm_none;  // R format
  end

  imm_gen u_imm_gen (.i_inst(i_inst), .i_fmt(fmt), .o_imm(imm));

  mux_key #(.NR_KEY(19), .KEY_LEN(19), .DATA_LEN(5)) u_alu_mux (
    .i_key     (alu_key),
    .i_default (alu_none),
    .i_lut     ({19'b1000000000000000000, alu_copy_imm,
                 19'b0100000000000000000, alu_add,
                 19'b0010000000000000000, alu_sub,
                 19'b0001000000000000000, alu_slt,
                 19'b0000100000000000000, alu_sltu,
                 19'b0000010000000000000, alu_xor,
                 19'b0000001000000000000, alu_and,
                 19'b0000000100000000000, alu_or,
                 19'b0000000010000000000, alu_sll,
                 19'b0000000001000000000, alu_srl,
                 19'b0000000000100000000, alu_sra,
                 19'b0000000000010000000, alu_mul,
                 19'b0000000000001000000, alu_mulh,
                 19'b0000000000000100000, alu_mulhsu,
                 19'b0000000000000010000, alu_mulhu,
                 19'b0000000000000001000, alu_div,
                 19'b0000000000000000100, alu_divu,
                 19'b0000000000000000010, alu_rem,
                 19'b0000000000000000001, alu_remu}),
    .o_out     (alu_code)
  );

  // stores never have f3[2] set, so they share the load keys
  mux_key #(.NR_KEY(7), .KEY_LEN(4), .DATA_LEN(3)) u_mem_mux (
    .i_key     ({inst_load | inst_store, f3}),
    .i_default (mem_none),
    .i_lut     ({4'b1000, mem_byte,  4'b1100, mem_byte_u,
                 4'b1001, mem_half,  4'b1101, mem_half_u,
                 4'b1010, mem_word,  4'b1110, mem_word_u,
                 4'b1011, mem_dword}),
    .o_out     (mem_code)
  );

  mux_key #(.NR_KEY(8), .KEY_LEN(8), .DATA_LEN(3)) u_br_mux (
    .i_key     ({inst_jal, inst_jalr, inst_beq, inst_bne, inst_blt, inst_bge,
                 inst_bltu, inst_bgeu}),
    .i_default (br_none),
    .i_lut     ({8'b10000000, br_jal,  8'b01000000, br_jalr,
                 8'b00100000, br_eq,   8'b00010000, br_ne,
                 8'b00001000, br_lt,   8'b00000100, br_ge,
                 8'b00000010, br_lt,   8'b00000001, br_ge}),
    .o_out     (br_code)
  );

  always_comb begin
    if (inst_ebreak) ex_op = ex_ebreak;
    else if (inst_ecall) ex_op = ex_ecall;
    else if (inst_mret) ex_op = ex_mret;
    else if (inst_csrrw) ex_op = ex_csrrw;
    else if (inst_csrrs) ex_op = ex_csrrs;
    else ex_op = ex_none;
  end

  always_comb begin
    o_dec.alu_op     = alu_op_e'(alu_code);
    o_dec.a_is_pc    = inst_auipc | inst_jal | inst_jalr;
    if (inst_jal | inst_jalr) o_dec.b_src = b_four;  // link address pc + 4
    else if (type_i | type_u | inst_store | inst_branch) o_dec.b_src = b_imm;
    else o_dec.b_src = b_rs2;
    o_dec.word_cut   = (is_op32 | is_opimm32) & arith;
    o_dec.reg_wr     = type_r | type_i | type_u | inst_jal;
    o_dec.mem_to_reg = inst_load;
    o_dec.mem_wr     = inst_store;
    o_dec.mem_rd     = inst_load;
    o_dec.mem_op     = mem_op_e'(mem_code);
    o_dec.branch     = branch_e'(br_code);
    o_dec.ex_op      = ex_op;
    o_dec.csr_sel    = inst_csrrw | inst_csrrs | inst_ecall | inst_mret;
    o_dec.csr_wr     = inst_csrrw | (inst_csrrs & |i_inst[19:15]) | inst_ecall | inst_mret;
    o_dec.csr_rd     = inst_csrrs | (inst_csrrw & |i_inst[11:7]) | inst_ecall | inst_mret;
    o_dec.raise_intr = inst_ecall;
    o_dec.intr_ret   = inst_mret;
    o_dec.invalid    = (alu_code == alu_none) & (ex_op == ex_none) & (|i_inst);
    o_dec.rs1        = i_inst[19:15];
    o_dec.rs2        = i_inst[24:20];
    o_dec.rd         = i_inst[11:7];
    o_dec.imm        = imm;
    o_dec.zimm       = i_inst[19:15];
  end

endmodule

`default_nettype wire

// File: regfile.sv
// no write-to-read bypass; a write shows on the read ports only after its clock edge
`timescale 1ns/10ps
`default_nettype none

module regfile
  import idu_pkg::*;
(
  input  wire             i_clk,
  input  wire             i_rst,
  input  wire [4:0]       i_ra,
  input  wire [4:0]       i_rb,
  output logic [XLEN-1:0] o_rdata_a,
  output logic [XLEN-1:0] o_rdata_b,
  input  wire             i_we,
  input  wire [4:0]       i_wa,
  input  wire [XLEN-1:0]  i_wd
);

  logic [XLEN-1:0] regs [NR_REGS];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int n = 0; n < NR_REGS; n++) begin
        regs[n] <= '0;
      end
    end else if (i_we && (i_wa != 5'd0)) begin  // x0 writes dropped
      regs[i_wa] <= i_wd;
    end
  end

  assign o_rdata_a = (i_ra == 5'd0) ? '0 : regs[i_ra];
  assign o_rdata_b = (i_rb == 5'd0) ? '0 : regs[i_rb];

endmodule

`default_nettype wire

// File: decode_stage.sv
// one instruction in flight; a new request is taken only after both handshakes are back low
`timescale 1ns/10ps
`default_nettype none

module decode_stage
  import idu_pkg::*;
(
  input  wire           i_clk,
  input  wire           i_rst,
  input  wire           i_in_req,
  output logic          o_in_ack,
  input  wire decode_t  i_dec,
  input  wire operand_t i_opnd,
  output logic          o_out_req,
  input  wire           i_out_ack,
  output decode_t       o_dec,
  output operand_t      o_opnd
);

  typedef enum logic [1:0] {IDLE, BUSY, DRAIN} state_e;

  state_e state;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state     <= IDLE;
      o_in_ack  <= 1'b0;
      o_out_req <= 1'b0;
      o_dec     <= '0;
      o_opnd    <= '0;
    end else begin
      if (o_in_ack && !i_in_req) begin
        o_in_ack <= 1'b0;  // fetch released its request
      end
      case (state)
        IDLE: begin
          if (i_in_req) begin
            o_dec     <= i_dec;
            o_opnd    <= i_opnd;
            o_in_ack  <= 1'b1;
            o_out_req <= 1'b1;
            state     <= BUSY;
          end
        end
        BUSY: begin
          if (i_out_ack) begin
            o_out_req <= 1'b0;
            state     <= DRAIN;
          end
        end
        DRAIN: begin
          // fetch side is done once its ack is down or dropping at this edge
          if (!i_out_ack && (!o_in_ack || !i_in_req)) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  a_out_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    o_out_req && $past(o_out_req) |-> $stable(o_dec) && $stable(o_opnd))
    else $error("decode_stage: output changed under o_out_req");

  // execute must have dropped its ack before the next request goes out
  a_req_rise: assert property (@(posedge i_clk) disable iff (i_rst)
    $rose(o_out_req) |-> !$past(i_out_ack))
    else $error("decode_stage: o_out_req rose with i_out_ack high");

endmodule

`default_nettype wire

// File: decode_top.sv
// i_inst must hold while i_in_req is high; write-back must stay idle during a decode
`timescale 1ns/10ps
`default_nettype none

module decode_top
  import idu_pkg::*;
(
  input  wire            i_clk,
  input  wire            i_rst,
  input  wire            i_in_req,
  input  wire [31:0]     i_inst,
  output logic           o_in_ack,
  output logic           o_out_req,
  input  wire            i_out_ack,
  output decode_t        o_dec,
  output operand_t       o_opnd,
  input  wire            i_wb_en,
  input  wire [4:0]      i_wb_addr,
  input  wire [XLEN-1:0] i_wb_data
);

  decode_t         dec;
  operand_t        opnd;
  logic [XLEN-1:0] rdata_a;
  logic [XLEN-1:0] rdata_b;

  idu u_idu (
    .i_inst (i_inst),
    .o_dec  (dec)
  );

  regfile u_regfile (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_ra      (dec.rs1),
    .i_rb      (dec.rs2),
    .o_rdata_a (rdata_a),
    .o_rdata_b (rdata_b),
    .i_we      (i_wb_en),
    .i_wa      (i_wb_addr),
    .i_wd      (i_wb_data)
  );

  assign opnd = '{rs1_val: rdata_a, rs2_val: rdata_b};

  decode_stage u_stage (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_in_req  (i_in_req),
    .o_in_ack  (o_in_ack),
    .i_dec     (dec),
    .i_opnd    (opnd),
    .o_out_req (o_out_req),
    .i_out_ack (i_out_ack),
    .o_dec     (o_dec),
    .o_opnd    (o_opnd)
  );

endmodule

`default_nettype wire

// File: tb_decode_ref.svh
// needs idu_pkg imported by the including module; ecall/ebreak match on funct12 and funct3 only
`ifndef TB_DECODE_REF_SVH
`define TB_DECODE_REF_SVH

function automatic logic [63:0] sext(input logic [63:0] val, input int width);
  longint v;
  v = longint'(val) << (64 - width);
  return v >>> (64 - width);  // arithmetic shift back down
endfunction

function automatic alu_op_e rr_alu(input logic [2:0] f3, input logic [6:0] f7, input logic word);
  alu_op_e op;
  op = alu_none;
  if (f7 == 7'h00) begin
    case (f3)
      3'd0: op = alu_add;
      3'd1: op = alu_sll;
      3'd2: op = alu_slt;
      3'd3: op = alu_sltu;
      3'd4: op = alu_xor;
      3'd5: op = alu_srl;
      3'd6: op = alu_or;
      default: op = alu_and;
    endcase
    if (word && f3 != 3'd0 && f3 != 3'd1 && f3 != 3'd5) op = alu_none;
  end else if (f7 == 7'h20) begin
    if (f3 == 3'd0) op = alu_sub;
    else if (f3 == 3'd5) op = alu_sra;
  end else if (f7 == 7'h01) begin
    case (f3)
      3'd0: op = alu_mul;
      3'd1: op = alu_mulh;
      3'd2: op = alu_mulhsu;
      3'd3: op = alu_mulhu;
      3'd4: op = alu_div;
      3'd5: op = alu_divu;
      3'd6: op = alu_rem;
      default: op = alu_remu;
    endcase
    if (word && f3 != 3'd0 && !f3[2]) op = alu_none;  // no mulh* in W form
  end
  return op;
endfunction

function automatic alu_op_e ri_alu(input logic [2:0] f3, input logic [6:0] f7, input logic word);
  alu_op_e op;
  logic    sh_l;
  logic    sh_a;
  op   = alu_none;
  sh_l = word ? (f7 == 7'h00) : (f7[6:1] == 6'h00);  // 6-bit shamt outside W
  sh_a = word ? (f7 == 7'h20) : (f7[6:1] == 6'h10);
  case (f3)
    3'd0: op = alu_add;
    3'd1: if (sh_l) op = alu_sll;
    3'd2: op = alu_slt;
    3'd3: op = alu_sltu;
    3'd4: op = alu_xor;
    3'd5: begin
      if (sh_l) op = alu_srl;
      else if (sh_a) op = alu_sra;
    end
    3'd6: op = alu_or;
    default: op = alu_and;
  endcase
  if (word && f3 != 3'd0 && f3 != 3'd1 && f3 != 3'd5) op = alu_none;
  return op;
endfunction

function automatic decode_t ref_decode(input logic [31:0] inst);
  decode_t    d;
  logic [6:0] opc;
  logic [2:0] f3;
  logic [6:0] f7;
  logic       is_r;
  imm_fmt_e   fmt;
  opc      = inst[6:0];
  f3       = inst[14:12];
  f7       = inst[31:25];
  d        = '0;
  d.alu_op = alu_none;
  d.b_src  = b_rs2;
  d.mem_op = mem_none;
  d.branch = br_none;
  d.ex_op  = ex_none;
  fmt      = imm_none;
  is_r     = 1'b0;
  case (opc)
    opc_lui: begin
      d.alu_op = alu_copy_imm;
      fmt      = imm_u;
    end
    opc_auipc: begin
      d.alu_op  = alu_add;
      d.a_is_pc = 1'b1;
      fmt       = imm_u;
    end
    opc_jal: begin
      d.alu_op  = alu_add;
      d.a_is_pc = 1'b1;
      d.branch  = br_jal;
      fmt       = imm_j;
    end
    opc_jalr: begin
      if (f3 == 3'd0) begin
        d.alu_op  = alu_add;
        d.a_is_pc = 1'b1;
        d.branch  = br_jalr;
        fmt       = imm_i;
      end
    end
    opc_load: begin
      if (f3 != 3'd7) begin
        d.alu_op     = alu_add;
        d.mem_rd     = 1'b1;
        d.mem_to_reg = 1'b1;
        d.mem_op     = mem_op_e'({f3[1:0], f3[2]});  // size then unsigned
        fmt          = imm_i;
      end
    end
    opc_store: begin
      if (!f3[2]) begin
        d.alu_op = alu_add;
        d.mem_wr = 1'b1;
        d.mem_op = mem_op_e'({f3[1:0], 1'b0});
        fmt      = imm_s;
      end
    end
    opc_branch: begin
      if (f3[2:1] != 2'b01) begin
        d.alu_op = f3[1] ? alu_sltu : alu_slt;
        if (f3[2]) d.branch = f3[0] ? br_ge : br_lt;
        else d.branch = f3[0] ? br_ne : br_eq;
        fmt = imm_b;
      end
    end
    opc_op_imm, opc_op_imm_32: begin
      d.alu_op = ri_alu(f3, f7, opc == opc_op_imm_32);
      if (d.alu_op != alu_none) fmt = imm_i;
    end
    opc_op, opc_op_32: begin
      d.alu_op = rr_alu(f3, f7, opc == opc_op_32);
      is_r     = d.alu_op != alu_none;
    end
    opc_system: begin
      if (f3 == 3'd1) begin
        d.ex_op = ex_csrrw;
        fmt     = imm_i;
      end else if (f3 == 3'd2) begin
        d.ex_op = ex_csrrs;
        fmt     = imm_i;
      end else if (f3 == 3'd0 && inst[31:20] == 12'h000) begin
        d.ex_op = ex_ecall;
      end else if (f3 == 3'd0 && inst[31:20] == 12'h001) begin
        d.ex_op = ex_ebreak;
        fmt     = imm_i;
      end else if (inst == 32'h3020_0073) begin
        d.ex_op = ex_mret;
      end
    end
    default: ;
  endcase

  d.word_cut = (opc == opc_op_32 || opc == opc_op_imm_32) && d.alu_op != alu_none;
  d.reg_wr   = is_r || fmt == imm_i || fmt == imm_u || fmt == imm_j;
  if (d.branch == br_jal || d.branch == br_jalr) d.b_src = b_four;
  else if (fmt != imm_none) d.b_src = b_imm;
  d.csr_sel    = d.ex_op == ex_csrrw || d.ex_op == ex_csrrs || d.ex_op == ex_ecall ||
                 d.ex_op == ex_mret;
  d.csr_wr     = d.ex_op == ex_csrrw || (d.ex_op == ex_csrrs && inst[19:15] != 5'd0) ||
                 d.ex_op == ex_ecall || d.ex_op == ex_mret;
  d.csr_rd     = d.ex_op == ex_csrrs || (d.ex_op == ex_csrrw && inst[11:7] != 5'd0) ||
                 d.ex_op == ex_ecall || d.ex_op == ex_mret;
  d.raise_intr = d.ex_op == ex_ecall;
  d.intr_ret   = d.ex_op == ex_mret;
  d.invalid    = d.alu_op == alu_none && d.ex_op == ex_none && inst != 32'd0;
  d.rs1        = inst[19:15];
  d.rs2        = inst[24:20];
  d.rd         = inst[11:7];
  d.zimm       = inst[19:15];
  case (fmt)
    imm_i: d.imm = sext(inst[31:20], 12);
    imm_s: d.imm = sext({inst[31:25], inst[11:7]}, 12);
    imm_b: d.imm = sext({inst[31], inst[7], inst[30:25], inst[11:8], 1'b0}, 13);
    imm_u: d.imm = sext({inst[31:12], 12'h000}, 32);
    imm_j: d.imm = sext({inst[31], inst[19:12], inst[20], inst[30:21], 1'b0}, 21);
    default: d.imm = '0;
  endcase
  return d;
endfunction

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [6:0] opc);
  return {f7, rs2, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] opc);
  return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
  return {imm[11:5], rs2, rs1, f3, imm[4:0], opc_store};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                      input logic [6:0] opc);
  return {imm, rd, opc};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
endfunction

`endif

// File: tb_decode.sv
// writes only while the stage is idle; random execute ack delay up to bp_max cycles
`timescale 1ns/10ps
`default_nettype none

module tb_decode
  import idu_pkg::*;
();

  localparam int TMO = 60;  // cycles per wait

  logic            clk;
  logic            rst;
  logic            i_in_req;
  logic [31:0]     i_inst;
  logic            o_in_ack;
  logic            o_out_req;
  logic            i_out_ack;
  decode_t         o_dec;
  operand_t        o_opnd;
  logic            i_wb_en;
  logic [4:0]      i_wb_addr;
  logic [XLEN-1:0] i_wb_data;

  logic [XLEN-1:0] shadow [32];
  logic [31:0]     exp_q [$];
  int              n_checked;
  int              last_lat;
  int              bp_max;
  int              ack_wait;
  logic            ack_armed;
  logic            out_req_q;
  logic            out_ack_q;
  logic            in_ack_q;
  logic            out_idle_q;
  decode_t         held_dec;
  operand_t        held_opnd;

  `include "tb_decode_ref.svh"

  decode_top u_dut (
    .i_clk     (clk),
    .i_rst     (rst),
    .i_in_req  (i_in_req),
    .i_inst    (i_inst),
    .o_in_ack  (o_in_ack),
    .o_out_req (o_out_req),
    .i_out_ack (i_out_ack),
    .o_dec     (o_dec),
    .o_opnd    (o_opnd),
    .i_wb_en   (i_wb_en),
    .i_wb_addr (i_wb_addr),
    .i_wb_data (i_wb_data)
  );

  always #2 clk = ~clk;

  task automatic abort(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check(input logic [255:0] got, input logic [255:0] exp, input string what);
    if (got !== exp) begin
      abort($sformatf("mismatch at %0t ns: %s, got %0h expected %0h", $time, what, got, exp));
    end
  endtask

  function automatic logic [4:0] rnd_reg();
    return 5'($urandom);
  endfunction

  function automatic logic [31:0] rand_rr();
    logic [6:0] f7;
    case ($urandom_range(2, 0))
      0: f7 = 7'h00;
      1: f7 = 7'h20;
      default: f7 = 7'h01;
    endcase
    return enc_r(f7, rnd_reg(), rnd_reg(), 3'($urandom), rnd_reg(),
                 $urandom_range(1, 0) ? opc_op_32 : opc_op);
  endfunction

  function automatic logic [31:0] rand_ri();
    logic [11:0] imm;
    logic [2:0]  f3;
    imm = 12'($urandom);
    f3  = 3'($urandom);
    if (f3 == 3'd1 || f3 == 3'd5) begin
      case ($urandom_range(3, 0))
        0: imm[11:5] = 7'h00;
        1: imm[11:5] = 7'h20;
        2: imm[11:5] = 7'h01;  // shamt >= 32
        default: ;
      endcase
    end
    return enc_i(imm, rnd_reg(), f3, rnd_reg(),
                 $urandom_range(1, 0) ? opc_op_imm_32 : opc_op_imm);
  endfunction

  function automatic logic [31:0] rand_any();
    case ($urandom_range(3, 0))
      0: return rand_rr();
      1: return rand_ri();
      2: return enc_i(12'($urandom), rnd_reg(), 3'($urandom), rnd_reg(), opc_load);
      default: return enc_b({12'($urandom), 1'b0}, rnd_reg(), rnd_reg(), 3'($urandom));
    endcase
  endfunction

  // fetch agent returns once o_in_ack is seen
  task automatic send_inst(input logic [31:0] inst);
    int n;
    n = 0;
    while (o_in_ack) begin
      @(posedge clk);
      #1;
      n++;
      if (n > TMO) abort("timeout: o_in_ack stayed high after the request was dropped");
    end
    i_inst   = inst;
    i_in_req = 1'b1;
    exp_q.push_back(inst);
    n = 0;
    while (!o_in_ack) begin
      @(posedge clk);
      #1;
      n++;
      if (n > TMO) abort($sformatf("timeout: no o_in_ack for instruction %h", inst));
    end
    last_lat = n;
    i_in_req = 1'b0;
    i_inst   = $urandom;
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (exp_q.size() != 0 || o_in_ack || o_out_req || i_out_ack) begin
      @(posedge clk);
      #1;
      n++;
      if (n > TMO) abort("timeout: decode stage did not return to idle");
    end
  endtask

  task automatic write_reg(input logic [4:0] addr, input logic [XLEN-1:0] data);
    i_wb_en   = 1'b1;
    i_wb_addr = addr;
    i_wb_data = data;
    @(posedge clk);
    #1;
    i_wb_en = 1'b0;
    if (addr != 5'd0) shadow[addr] = data;
  endtask

  // execute side
  always @(posedge clk) begin
    #1;
    if (rst) begin
      i_out_ack = 1'b0;
      ack_armed = 1'b0;
    end else if (o_out_req && !i_out_ack) begin
      if (!ack_armed) begin
        ack_armed = 1'b1;
        ack_wait  = (bp_max > 0) ? $urandom_range(bp_max, 0) : 0;
      end
      if (ack_wait == 0) begin
        i_out_ack = 1'b1;
        ack_armed = 1'b0;
      end else begin
        ack_wait--;
      end
    end else if (!o_out_req && i_out_ack) begin
      i_out_ack = 1'b0;
    end
  end

  // compare at mid-cycle
  always @(negedge clk) begin
    decode_t     exp_dec;
    operand_t    exp_opnd;
    logic [31:0] inst;
    if (rst) begin
      out_req_q  = 1'b0;
      out_ack_q  = 1'b0;
      in_ack_q   = 1'b0;
      out_idle_q = 1'b1;
    end else begin
      if (o_in_ack && !in_ack_q) begin
        check(out_idle_q, 1'b1, "o_in_ack rose before the execute handshake returned low");
        check(o_out_req, 1'b1, "o_out_req together with o_in_ack");
      end
      if (o_out_req && !out_req_q) begin
        if (exp_q.size() == 0) begin
          abort("o_out_req rose with no instruction sent");
        end else begin
          inst             = exp_q.pop_front();
          exp_dec          = ref_decode(inst);
          exp_opnd.rs1_val = shadow[exp_dec.rs1];
          exp_opnd.rs2_val = shadow[exp_dec.rs2];
          check(o_dec, exp_dec, $sformatf("o_dec for %h", inst));
          check(o_opnd, exp_opnd, $sformatf("o_opnd for %h", inst));
          held_dec  = o_dec;
          held_opnd = o_opnd;
          n_checked++;
        end
      end else if (o_out_req) begin
        check(o_dec, held_dec, "o_dec changed while o_out_req high");
        check(o_opnd, held_opnd, "o_opnd changed while o_out_req high");
      end else if (out_req_q) begin
        check(out_ack_q, 1'b1, "o_out_req dropped before i_out_ack was raised");
      end
      out_req_q  = o_out_req;
      out_ack_q  = i_out_ack;
      in_ack_q   = o_in_ack;
      out_idle_q = !o_out_req && !i_out_ack;
    end
  end

  initial begin
    void'($urandom(32'h35e2_31ef));
    clk       = 1'b0;
    rst       = 1'b1;
    i_in_req  = 1'b0;
    i_inst    = '0;
    i_out_ack = 1'b0;
    i_wb_en   = 1'b0;
    i_wb_addr = '0;
    i_wb_data = '0;
    bp_max    = 0;
    n_checked = 0;
    for (int r = 0; r < 32; r++) begin
      shadow[r] = '0;
    end
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;

    check(o_in_ack, 1'b0, "o_in_ack after reset");
    check(o_out_req, 1'b0, "o_out_req after reset");
    send_inst(enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd1, opc_op));
    check(last_lat, 1, "cycles from i_in_req to o_in_ack");
    check(o_out_req, 1'b1, "o_out_req one cycle after i_in_req");

    wait_idle();
    for (int r = 0; r < 32; r++) begin
      write_reg(5'(r), {$urandom, $urandom});  // r = 0 must be dropped
    end

    repeat (40) send_inst(rand_rr());
    repeat (40) send_inst(rand_ri());
    send_inst(enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd5, opc_op));  // x0 operands

    for (int f = 0; f < 8; f++) begin
      send_inst(enc_i(12'($urandom), rnd_reg(), 3'(f), rnd_reg(), opc_load));
      send_inst(enc_s(12'($urandom), rnd_reg(), rnd_reg(), 3'(f)));
    end

    for (int f = 0; f < 8; f++) begin
      repeat (2) send_inst(enc_b({12'($urandom), 1'b0}, rnd_reg(), rnd_reg(), 3'(f)));
    end
    repeat (4) send_inst(enc_j({20'($urandom), 1'b0}, rnd_reg()));
    send_inst(enc_i(12'($urandom), rnd_reg(), 3'd0, rnd_reg(), opc_jalr));
    send_inst(enc_i(12'($urandom), rnd_reg(), 3'd1, rnd_reg(), opc_jalr));
    repeat (3) send_inst(enc_u(20'($urandom), rnd_reg(), opc_lui));
    repeat (3) send_inst(enc_u(20'($urandom), rnd_reg(), opc_auipc));

    for (int k = 0; k < 8; k++) begin
      send_inst(enc_i(12'($urandom), k[0] ? 5'($urandom_range(31, 1)) : 5'd0,
                      k[2] ? 3'd2 : 3'd1, k[1] ? 5'($urandom_range(31, 1)) : 5'd0,
                      opc_system));
    end
    send_inst(32'h0000_0073);  // ecall
    send_inst(32'h0010_0073);  // ebreak
    send_inst(INST_MRET);
    send_inst(32'h0000_0000);
    send_inst(enc_b(13'h0, 5'd1, 5'd2, 3'd2));
    send_inst(enc_r(7'h02, 5'd3, 5'd4, 3'd0, 5'd5, opc_op));
    repeat (8) send_inst({30'($urandom), 2'b01});

    // back-pressure with the next request already waiting
    wait_idle();
    bp_max = 6;
    repeat (24) send_inst(rand_any());
    wait_idle();
    bp_max = 0;

    $display("%0d decodes compared", n_checked);
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
+incdir+.
idu_pkg.sv
mux_key.sv
imm_gen.sv
idu.sv
regfile.sv
decode_stage.sv
decode_top.sv
tb_decode.sv
